// ==== Bender.yml ====
package:
  name: sha_nonce_core

sources:
  # RTL
  - files:
      - source/sha_pkg.sv
      - source/sha_round.sv
      - source/nonce_counter.sv
      - source/sha_pre_pipeline.sv
      - source/sha_schedule_pipeline.sv
      - source/sha_final_add.sv
      - source/sha_nonce_core.sv
  # Testbench
  - target: test
    files:
      - verification/sha_nonce_core_chk.sv
      - verification/sha_nonce_checker.sv
      - verification/tb_sha_nonce_core.sv

// ==== files.f ====
source/sha_pkg.sv
source/sha_round.sv
source/nonce_counter.sv
source/sha_pre_pipeline.sv
source/sha_schedule_pipeline.sv
source/sha_final_add.sv
source/sha_nonce_core.sv
verification/sha_nonce_core_chk.sv
verification/sha_nonce_checker.sv
verification/tb_sha_nonce_core.sv

// ==== source/nonce_counter.sv ====
module nonce_counter #(
	parameter logic [31:0] INITIAL_COUNT = 32'd0,
	parameter logic [31:0] INCREMENT     = 32'd1
) (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        load,
	input  logic        step,
	output logic [31:0] count
);

	// Nonce to hand to the next item that does not start a block
	logic [31:0] next_count;

	// count holds the nonce of the item that just passed the tap
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count      <= INITIAL_COUNT;
			next_count <= INITIAL_COUNT;
		end else if (load) begin
			// New block restarts the sequence
			count      <= INITIAL_COUNT;
			next_count <= INITIAL_COUNT + INCREMENT;
		end else if (step) begin
			count      <= next_count;
			next_count <= next_count + INCREMENT;
		end
	end

endmodule

// ==== source/sha_final_add.sv ====
module sha_final_add (
	input  logic                clk,
	input  logic                rst_n,
	input  sha_pkg::hash_state_t state_i,
	input  sha_pkg::hash_state_t midstate_i,
	input  logic                valid_i,
	input  logic [31:0]         nonce_i,
	output sha_pkg::hash_state_t digest,
	output logic [31:0]         nonce,
	output logic                valid
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid <= 1'b0;
		end else begin
			valid <= valid_i;
		end
	end

	// Feed-forward of the chaining value, word by word mod 2^32
	always_ff @(posedge clk) begin
		digest.a <= state_i.a + midstate_i.a;
		digest.b <= state_i.b + midstate_i.b;
		digest.c <= state_i.c + midstate_i.c;
		digest.d <= state_i.d + midstate_i.d;
		digest.e <= state_i.e + midstate_i.e;
		digest.f <= state_i.f + midstate_i.f;
		digest.g <= state_i.g + midstate_i.g;
		digest.h <= state_i.h + midstate_i.h;
		nonce    <= nonce_i;
	end

endmodule

// ==== source/sha_nonce_core.sv ====
module sha_nonce_core #(
	parameter logic [31:0] PROCESSOR_INDEX = 32'd0,
	parameter logic [31:0] NUM_PROCESSORS  = 32'd1
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                in_valid,
	input  logic                in_newblock,
	input  sha_pkg::hash_state_t in_midstate,
	input  logic [31:0]         in_w0,
	input  logic [31:0]         in_w1,
	input  logic [31:0]         in_w2,
	output logic                out_valid,
	output sha_pkg::hash_state_t out_digest,
	output logic [31:0]         out_nonce
);

	// Stage 15 handoff
	sha_pkg::hash_state_t pre_state;
	sha_pkg::hash_state_t pre_midstate;
	logic                 pre_valid;
	logic [15:0][31:0]    pre_window;
	logic [31:0]          pre_nonce;
	// Round 64 handoff
	sha_pkg::hash_state_t sched_state;
	sha_pkg::hash_state_t sched_midstate;
	logic                 sched_valid;
	logic [31:0]          sched_nonce;

	// Rounds 0 to 14, 15 cycles
	// Block mark is consumed by the nonce counters inside
	sha_pre_pipeline #(
		.PROCESSOR_INDEX(PROCESSOR_INDEX),
		.NUM_PROCESSORS (NUM_PROCESSORS)
	) u_pre (
		.clk,
		.rst_n,
		.valid_i   (in_valid),
		.newblock_i(in_newblock),
		.midstate_i(in_midstate),
		.w0        (in_w0),
		.w1        (in_w1),
		.w2        (in_w2),
		.state_o   (pre_state),
		.midstate_o(pre_midstate),
		.valid_o   (pre_valid),
		.newblock_o(),
		.window_o  (pre_window),
		.nonce_o   (pre_nonce)
	);

	// Rounds 15 to 63, 49 cycles
	sha_schedule_pipeline u_sched (
		.clk,
		.rst_n,
		.state_i   (pre_state),
		.midstate_i(pre_midstate),
		.valid_i   (pre_valid),
		.window_i  (pre_window),
		.nonce_i   (pre_nonce),
		.state_o   (sched_state),
		.midstate_o(sched_midstate),
		.valid_o   (sched_valid),
		.nonce_o   (sched_nonce)
	);

	// Midstate add, one more cycle
	sha_final_add u_final (
		.clk,
		.rst_n,
		.state_i   (sched_state),
		.midstate_i(sched_midstate),
		.valid_i   (sched_valid),
		.nonce_i   (sched_nonce),
		.digest    (out_digest),
		.nonce     (out_nonce),
		.valid     (out_valid)
	);

endmodule

// ==== source/sha_pkg.sv ====
package sha_pkg;

	// Working variables a to h, a in the top word
	typedef struct packed {
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		logic [31:0] d;
		logic [31:0] e;
		logic [31:0] f;
		logic [31:0] g;
		logic [31:0] h;
	} hash_state_t;

	// Single one bit that follows the message
	localparam logic [31:0] PAD_WORD = 32'h8000_0000;
	// 80-byte header, so 640 bits in the last word
	localparam logic [31:0] MSG_LENGTH_BITS = 32'd640;

	// Round constants, index 0 first
	localparam logic [31:0] K_TABLE [64] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// Constant for one round, usable in parameter context
	function automatic logic [31:0] round_k(input int unsigned idx);
		return K_TABLE[idx];
	endfunction

	// Standard initial hash value H0
	function automatic hash_state_t initial_state();
		return '{a: 32'h6a09e667, b: 32'hbb67ae85, c: 32'h3c6ef372, d: 32'ha54ff53a,
			e: 32'h510e527f, f: 32'h9b05688c, g: 32'h1f83d9ab, h: 32'h5be0cd19};
	endfunction

	function automatic logic [31:0] rotr(input logic [31:0] x, input int unsigned n);
		return (x >> n) | (x << (32 - n));
	endfunction

	// Compression functions on a and e
	function automatic logic [31:0] big_sigma0(input logic [31:0] x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic logic [31:0] big_sigma1(input logic [31:0] x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	// Message schedule functions
	function automatic logic [31:0] small_sigma0(input logic [31:0] x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic logic [31:0] small_sigma1(input logic [31:0] x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	// e picks between f and g
	function automatic logic [31:0] ch(input logic [31:0] e, f, g);
		return (e & f) ^ (~e & g);
	endfunction

	// Bitwise vote of a, b and c
	function automatic logic [31:0] maj(input logic [31:0] a, b, c);
		return (a & b) ^ (a & c) ^ (b & c);
	endfunction

endpackage

// ==== source/sha_pre_pipeline.sv ====
module sha_pre_pipeline #(
	parameter logic [31:0] PROCESSOR_INDEX = 32'd0,
	parameter logic [31:0] NUM_PROCESSORS  = 32'd1
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                valid_i,
	input  logic                newblock_i,
	input  sha_pkg::hash_state_t midstate_i,
	input  logic [31:0]         w0,
	input  logic [31:0]         w1,
	input  logic [31:0]         w2,
	output sha_pkg::hash_state_t state_o,
	output sha_pkg::hash_state_t midstate_o,
	output logic                valid_o,
	output logic                newblock_o,
	output logic [15:0][31:0]   window_o,
	output logic [31:0]         nonce_o
);

	// Index n is the value entering round n, index 15 leaves the module
	logic                 valid_pipe    [16];
	logic                 newblock_pipe [16];
	sha_pkg::hash_state_t state_pipe    [16];
	sha_pkg::hash_state_t mid_pipe      [16];
	// Header words w0 to w2 delayed alongside the rounds
	logic [2:0][31:0]     words_pipe    [16];
	// Message words for rounds 0 to 14
	logic [31:0]          msg           [15];

	assign valid_pipe[0]    = valid_i;
	assign newblock_pipe[0] = newblock_i;
	// Working state starts from the midstate
	assign state_pipe[0]    = midstate_i;
	assign mid_pipe[0]      = midstate_i;
	assign words_pipe[0]    = {w2, w1, w0};

	for (genvar n = 0; n < 15; n++) begin : g_words
		always_ff @(posedge clk) begin
			words_pipe[n + 1] <= words_pipe[n];
		end
	end

	// Each header word is used by its round at its own depth
	assign msg[0] = words_pipe[0][0];
	assign msg[1] = words_pipe[1][1];
	assign msg[2] = words_pipe[2][2];

	// Tap after stage 2, so the item at stage 3 reads its own nonce
	nonce_counter #(
		.INITIAL_COUNT(PROCESSOR_INDEX),
		.INCREMENT    (NUM_PROCESSORS)
	) u_nonce_early (
		.clk,
		.rst_n,
		.load (valid_pipe[2] & newblock_pipe[2]),
		.step (valid_pipe[2]),
		.count(msg[3])
	);

	assign msg[4] = sha_pkg::PAD_WORD;

	// Zero padding up to the length word
	for (genvar n = 5; n < 15; n++) begin : g_zero
		assign msg[n] = 32'd0;
	end

	// Second copy regenerates the same nonce at stage 15
	nonce_counter #(
		.INITIAL_COUNT(PROCESSOR_INDEX),
		.INCREMENT    (NUM_PROCESSORS)
	) u_nonce_late (
		.clk,
		.rst_n,
		.load (valid_pipe[14] & newblock_pipe[14]),
		.step (valid_pipe[14]),
		.count(nonce_o)
	);

	// Rounds 0 to 14
	for (genvar i = 0; i < 15; i++) begin : g_round
		sha_round #(.ROUND(i)) u_round (
			.clk,
			.rst_n,
			.state_i   (state_pipe[i]),
			.midstate_i(mid_pipe[i]),
			.w         (msg[i]),
			.valid_i   (valid_pipe[i]),
			.newblock_i(newblock_pipe[i]),
			.state_o   (state_pipe[i + 1]),
			.midstate_o(mid_pipe[i + 1]),
			.valid_o   (valid_pipe[i + 1]),
			.newblock_o(newblock_pipe[i + 1])
		);
	end

	assign state_o    = state_pipe[15];
	assign midstate_o = mid_pipe[15];
	assign valid_o    = valid_pipe[15];
	assign newblock_o = newblock_pipe[15];

	// Window for round 15, W0 in the top slot and W15 in slot 0
	assign window_o[15]   = words_pipe[15][0];
	assign window_o[14]   = words_pipe[15][1];
	assign window_o[13]   = words_pipe[15][2];
	assign window_o[12]   = nonce_o;
	assign window_o[11]   = sha_pkg::PAD_WORD;
	assign window_o[10:1] = '0;
	assign window_o[0]    = sha_pkg::MSG_LENGTH_BITS;

endmodule

// ==== source/sha_round.sv ====
module sha_round #(
	parameter int unsigned ROUND = 0
) (
	input  logic                clk,
	input  logic                rst_n,
	input  sha_pkg::hash_state_t state_i,
	input  sha_pkg::hash_state_t midstate_i,
	input  logic [31:0]         w,
	input  logic                valid_i,
	input  logic                newblock_i,
	output sha_pkg::hash_state_t state_o,
	output sha_pkg::hash_state_t midstate_o,
	output logic                valid_o,
	output logic                newblock_o
);

	// Fixed constant for this stage
	localparam logic [31:0] K = sha_pkg::round_k(ROUND);

	logic [31:0]          t1;
	logic [31:0]          t2;
	sha_pkg::hash_state_t next_state;

	always_comb begin
		t1 = state_i.h + sha_pkg::big_sigma1(state_i.e)
			+ sha_pkg::ch(state_i.e, state_i.f, state_i.g) + K + w;
		t2 = sha_pkg::big_sigma0(state_i.a) + sha_pkg::maj(state_i.a, state_i.b, state_i.c);
		// Shift the working words down by one
		next_state.a = t1 + t2;
		next_state.b = state_i.a;
		next_state.c = state_i.b;
		next_state.d = state_i.c;
		next_state.e = state_i.d + t1;
		next_state.f = state_i.e;
		next_state.g = state_i.f;
		next_state.h = state_i.g;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_o <= 1'b0;
		end else begin
			valid_o <= valid_i;
		end
	end

	// Payload travels with the valid bit
	always_ff @(posedge clk) begin
		state_o    <= next_state;
		midstate_o <= midstate_i;
		newblock_o <= newblock_i;
	end

endmodule

// ==== source/sha_schedule_pipeline.sv ====
module sha_schedule_pipeline (
	input  logic                clk,
	input  logic                rst_n,
	input  sha_pkg::hash_state_t state_i,
	input  sha_pkg::hash_state_t midstate_i,
	input  logic                valid_i,
	input  logic [15:0][31:0]   window_i,
	input  logic [31:0]         nonce_i,
	output sha_pkg::hash_state_t state_o,
	output sha_pkg::hash_state_t midstate_o,
	output logic                valid_o,
	output logic [31:0]         nonce_o
);

	// Index j enters round 15 + j, index 49 leaves after round 63
	logic                 valid_pipe  [50];
	sha_pkg::hash_state_t state_pipe  [50];
	sha_pkg::hash_state_t mid_pipe    [50];
	logic [31:0]          nonce_pipe  [50];
	// Slot m holds W[r - m] for the round r of that stage
	logic [15:0][31:0]    window_pipe [49];

	assign valid_pipe[0]  = valid_i;
	assign state_pipe[0]  = state_i;
	assign mid_pipe[0]    = midstate_i;
	assign nonce_pipe[0]  = nonce_i;
	assign window_pipe[0] = window_i;

	for (genvar j = 0; j < 49; j++) begin : g_stage
		// Slot 0 is the word for this round
		// Block marks are not needed past the nonce taps
		sha_round #(.ROUND(15 + j)) u_round (
			.clk,
			.rst_n,
			.state_i   (state_pipe[j]),
			.midstate_i(mid_pipe[j]),
			.w         (window_pipe[j][0]),
			.valid_i   (valid_pipe[j]),
			.newblock_i(1'b0),
			.state_o   (state_pipe[j + 1]),
			.midstate_o(mid_pipe[j + 1]),
			.valid_o   (valid_pipe[j + 1]),
			.newblock_o()
		);

		// Nonce rides along for the result
		always_ff @(posedge clk) begin
			nonce_pipe[j + 1] <= nonce_pipe[j];
		end

		// Last round needs no further schedule word
		if (j < 48) begin : g_expand
			logic [31:0] w_next;

			// W[r+1] from W[r-1], W[r-6], W[r-14] and W[r-15]
			assign w_next = sha_pkg::small_sigma1(window_pipe[j][1]) + window_pipe[j][6]
				+ sha_pkg::small_sigma0(window_pipe[j][14]) + window_pipe[j][15];

			// Oldest word drops out, new word enters slot 0
			always_ff @(posedge clk) begin
				window_pipe[j + 1] <= {window_pipe[j][14:0], w_next};
			end
		end
	end

	assign state_o    = state_pipe[49];
	assign midstate_o = mid_pipe[49];
	assign valid_o    = valid_pipe[49];
	assign nonce_o    = nonce_pipe[49];

endmodule

// ==== verification/sha_nonce_checker.sv ====
module sha_nonce_checker #(
	parameter logic [31:0] PROCESSOR_INDEX = 32'd0,
	parameter logic [31:0] NUM_PROCESSORS  = 32'd1
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 in_valid,
	input  logic                 in_newblock,
	input  sha_pkg::hash_state_t in_midstate,
	input  logic [31:0]          in_w0,
	input  logic [31:0]          in_w1,
	input  logic [31:0]          in_w2,
	input  logic                 out_valid,
	input  sha_pkg::hash_state_t out_digest,
	input  logic [31:0]          out_nonce,
	input  logic                 test_done,
	output int                   errors,
	output int                   checks,
	output int                   pending
);

	sha_pkg::hash_state_t exp_digest_q [$];
	logic [31:0]          exp_nonce_q  [$];
	logic [31:0]          next_nonce;
	int                   err_cnt = 0;
	int                   chk_cnt = 0;
	int                   pend_cnt = 0;

	assign errors  = err_cnt;
	assign checks  = chk_cnt;
	assign pending = pend_cnt;

	// One full SHA-256 block compression with the feed-forward add
	// blk[0] is the first message word
	function automatic sha_pkg::hash_state_t compress(input sha_pkg::hash_state_t chain,
			input logic [15:0][31:0] blk);
		logic [31:0]          w [64];
		logic [31:0]          t1;
		logic [31:0]          t2;
		sha_pkg::hash_state_t s;
		sha_pkg::hash_state_t res;
		for (int t = 0; t < 64; t++) begin
			if (t < 16) begin
				w[t] = blk[t];
			end else begin
				w[t] = sha_pkg::small_sigma1(w[t - 2]) + w[t - 7]
					+ sha_pkg::small_sigma0(w[t - 15]) + w[t - 16];
			end
		end
		s = chain;
		for (int t = 0; t < 64; t++) begin
			t1 = s.h + sha_pkg::big_sigma1(s.e) + sha_pkg::ch(s.e, s.f, s.g)
				+ sha_pkg::round_k(t) + w[t];
			t2 = sha_pkg::big_sigma0(s.a) + sha_pkg::maj(s.a, s.b, s.c);
			s = '{a: t1 + t2, b: s.a, c: s.b, d: s.c, e: s.d + t1, f: s.e, g: s.f, h: s.g};
		end
		res.a = chain.a + s.a;
		res.b = chain.b + s.b;
		res.c = chain.c + s.c;
		res.d = chain.d + s.d;
		res.e = chain.e + s.e;
		res.f = chain.f + s.f;
		res.g = chain.g + s.g;
		res.h = chain.h + s.h;
		return res;
	endfunction

	// Second header block: tail words, nonce, padding, length
	function automatic sha_pkg::hash_state_t expected_digest(input sha_pkg::hash_state_t mid,
			input logic [31:0] w0, w1, w2, nonce);
		logic [15:0][31:0] blk;
		blk     = '0;
		blk[0]  = w0;
		blk[1]  = w1;
		blk[2]  = w2;
		blk[3]  = nonce;
		blk[4]  = sha_pkg::PAD_WORD;
		blk[15] = sha_pkg::MSG_LENGTH_BITS;
		return compress(mid, blk);
	endfunction

	always @(posedge clk or negedge rst_n) begin : compare
		logic [31:0]          nonce;
		sha_pkg::hash_state_t want;
		logic [31:0]          want_nonce;
		if (!rst_n) begin
			// In-flight items are dropped by the core
			exp_digest_q.delete();
			exp_nonce_q.delete();
			next_nonce = PROCESSOR_INDEX;
		end else begin
			// Pop first so a result never meets its own item
			if (out_valid) begin
				if (exp_nonce_q.size() == 0) begin
					$display("%0t: result appeared with no item in flight", $time);
					err_cnt++;
				end else begin
					want       = exp_digest_q.pop_front();
					want_nonce = exp_nonce_q.pop_front();
					chk_cnt++;
					if (out_nonce !== want_nonce) begin
						$display("ERR %0t: nonce %h, expected %h", $time, out_nonce, want_nonce);
						err_cnt++;
					end
					if (out_digest !== want) begin
						$display("ERR %0t: digest %h, expected %h (nonce %h)", $time,
							out_digest, want, want_nonce);
						err_cnt++;
					end
				end
			end
			if (in_valid) begin
				nonce      = in_newblock ? PROCESSOR_INDEX : next_nonce;
				next_nonce = nonce + NUM_PROCESSORS;
				exp_digest_q.push_back(expected_digest(in_midstate, in_w0, in_w1, in_w2, nonce));
				exp_nonce_q.push_back(nonce);
			end
		end
		pend_cnt = exp_nonce_q.size();
	end

	// Leftover items mean results went missing
	always @(posedge test_done) begin
		if (exp_nonce_q.size() != 0) begin
			$display("%0d items never produced a result", exp_nonce_q.size());
			err_cnt++;
		end
	end

endmodule

// ==== verification/sha_nonce_core_chk.sv ====
module sha_nonce_core_chk #(
	parameter logic [31:0] NUM_PROCESSORS = 32'd1
) (
	input logic        clk,
	input logic        rst_n,
	input logic        in_valid,
	input logic        in_newblock,
	input logic        out_valid,
	input logic [31:0] out_nonce
);

	int unsigned fail_count = 0;

	// Bit 64 lines up with the item now at the output
	logic [64:0] valid_hist;
	logic [64:0] block_hist;
	// Nonce of the previous result since reset
	logic [31:0] last_nonce;
	logic        have_last;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			valid_hist <= '0;
			block_hist <= '0;
			have_last  <= 1'b0;
		end else begin
			valid_hist <= {valid_hist[63:0], in_valid};
			block_hist <= {block_hist[63:0], in_valid & in_newblock};
			if (out_valid) begin
				have_last <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (out_valid) begin
			last_nonce <= out_nonce;
		end
	end

	// Valid bits cleared asynchronously
	a_quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
		else begin
			$error("out_valid high during reset");
			fail_count++;
		end

	// Fixed latency, no items lost or created
	a_latency: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid == valid_hist[64])
		else begin
			$error("out_valid does not follow in_valid by 65 cycles");
			fail_count++;
		end

	// Within one block the nonce advances by the step
	a_nonce_step: assert property (@(posedge clk) disable iff (!rst_n)
		(out_valid && !block_hist[64] && have_last) |-> (out_nonce == last_nonce + NUM_PROCESSORS))
		else begin
			$error("nonce step within a block is wrong");
			fail_count++;
		end

endmodule

// ==== verification/tb_sha_nonce_core.sv ====
module tb_sha_nonce_core;

	localparam logic [31:0] PROC_INDEX = 32'd3;
	localparam logic [31:0] PROC_COUNT = 32'd5;
	localparam int          CLK_PERIOD = 40;
	// Pipeline latency plus slack for one drain
	localparam int          DRAIN_LIMIT = 80;
	// Sends and idles of all phases, one drain per phase, then slack
	localparam int          STIM_CYCLES = 320;
	localparam int          NUM_DRAINS  = 5;
	localparam int          TIMEOUT_CYCLES = STIM_CYCLES + NUM_DRAINS * DRAIN_LIMIT + 200;

	logic                 clk;
	logic                 rst_n;
	logic                 in_valid;
	logic                 in_newblock;
	sha_pkg::hash_state_t in_midstate;
	logic [31:0]          in_w0;
	logic [31:0]          in_w1;
	logic [31:0]          in_w2;
	logic                 out_valid;
	sha_pkg::hash_state_t out_digest;
	logic [31:0]          out_nonce;
	logic                 test_done;
	int                   errors;
	int                   checks;
	int                   pending;

	integer               seed = 32'h746d1fc4;
	int                   sent_count = 0;
	int                   lost_count = 0;
	int                   assert_fails;
	logic [15:0][31:0]    first_blk;
	sha_pkg::hash_state_t genesis_mid;
	sha_pkg::hash_state_t mid;
	logic [31:0]          a;
	logic [31:0]          b;
	logic [31:0]          c;
	int                   gap;

	initial clk = 1'b0;
	always #(CLK_PERIOD / 2) clk = ~clk;

	sha_nonce_core #(
		.PROCESSOR_INDEX(PROC_INDEX),
		.NUM_PROCESSORS (PROC_COUNT)
	) DUT (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_newblock(in_newblock),
		.in_midstate(in_midstate),
		.in_w0      (in_w0),
		.in_w1      (in_w1),
		.in_w2      (in_w2),
		.out_valid  (out_valid),
		.out_digest (out_digest),
		.out_nonce  (out_nonce)
	);

	sha_nonce_checker #(
		.PROCESSOR_INDEX(PROC_INDEX),
		.NUM_PROCESSORS (PROC_COUNT)
	) u_checker (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_newblock(in_newblock),
		.in_midstate(in_midstate),
		.in_w0      (in_w0),
		.in_w1      (in_w1),
		.in_w2      (in_w2),
		.out_valid  (out_valid),
		.out_digest (out_digest),
		.out_nonce  (out_nonce),
		.test_done  (test_done),
		.errors     (errors),
		.checks     (checks),
		.pending    (pending)
	);

	bind sha_nonce_core sha_nonce_core_chk #(.NUM_PROCESSORS(NUM_PROCESSORS)) u_chk (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_newblock(in_newblock),
		.out_valid  (out_valid),
		.out_nonce  (out_nonce)
	);

	// One strobe, held only until the next edge
	task automatic send_item(input logic nb, input sha_pkg::hash_state_t m,
			input logic [31:0] w0, w1, w2);
		@(posedge clk);
		in_valid    <= 1'b1;
		in_newblock <= nb;
		in_midstate <= m;
		in_w0       <= w0;
		in_w1       <= w1;
		in_w2       <= w2;
		sent_count++;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			in_valid    <= 1'b0;
			in_newblock <= 1'b0;
		end
	endtask

	task automatic random_item(output sha_pkg::hash_state_t m, output logic [31:0] w0, w1, w2);
		m = {$random(seed), $random(seed), $random(seed), $random(seed),
			$random(seed), $random(seed), $random(seed), $random(seed)};
		w0 = $random(seed);
		w1 = $random(seed);
		w2 = $random(seed);
	endtask

	// Read checker status away from the active edge
	// Stops waiting once the last item is well past the pipeline depth
	task automatic wait_drain();
		int n;
		idle_cycles(1);
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (pending != 0 && n < DRAIN_LIMIT);
	endtask

	initial begin
		rst_n       = 1'b0;
		in_valid    = 1'b0;
		in_newblock = 1'b0;
		in_midstate = '0;
		in_w0       = '0;
		in_w1       = '0;
		in_w2       = '0;
		test_done   = 1'b0;
		// Genesis header, first 64 bytes: version, zero hash, merkle head
		first_blk      = '0;
		first_blk[0]   = 32'h01000000;
		first_blk[9]   = 32'h3ba3edfd;
		first_blk[10]  = 32'h7a7b12b2;
		first_blk[11]  = 32'h7ac72c3e;
		first_blk[12]  = 32'h67768f61;
		first_blk[13]  = 32'h7fc81bc3;
		first_blk[14]  = 32'h888a5132;
		first_blk[15]  = 32'h3a9fb8aa;
		genesis_mid = u_checker.compress(sha_pkg::initial_state(), first_blk);
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;

		// Single item of a real header
		send_item(1'b1, genesis_mid, 32'h4b1e5e4a, 32'h29ab5f49, 32'hffff001d);
		wait_drain();

		// Forty back to back, one block
		for (int i = 0; i < 40; i++) begin
			send_item(i == 0, genesis_mid, 32'h4b1e5e4a, 32'h29ab5f49, 32'hffff001d);
		end
		wait_drain();

		// Block B starts while block A is still in the pipe
		random_item(mid, a, b, c);
		for (int i = 0; i < 12; i++) begin
			send_item(i == 0, genesis_mid, 32'h4b1e5e4a, 32'h29ab5f49, 32'hffff001d);
		end
		for (int i = 0; i < 12; i++) begin
			send_item(i == 0, mid, a, b, c);
		end
		wait_drain();

		// Random gaps and contents, occasional new block
		for (int i = 0; i < 30; i++) begin
			gap = {$random(seed)} % 4;
			idle_cycles(gap);
			random_item(mid, a, b, c);
			send_item((i == 0) || (($random(seed) & 7) == 0), mid, a, b, c);
		end
		wait_drain();

		// Reset with ten items in flight, all of them lost
		for (int i = 0; i < 10; i++) begin
			random_item(mid, a, b, c);
			send_item(i == 0, mid, a, b, c);
		end
		idle_cycles(20);
		lost_count = 10;
		rst_n <= 1'b0;
		idle_cycles(3);
		rst_n <= 1'b1;
		// Any result now would be a ghost
		idle_cycles(70);
		// No new-block mark, nonce must restart anyway
		for (int i = 0; i < 8; i++) begin
			random_item(mid, a, b, c);
			send_item(1'b0, mid, a, b, c);
		end
		wait_drain();

		@(posedge clk);
		test_done <= 1'b1;
		@(negedge clk);
		assert_fails = DUT.u_chk.fail_count;
		if (checks != sent_count - lost_count) begin
			$display("Only %0d of %0d expected results were seen", checks, sent_count - lost_count);
		end
		$display("Results checked: %0d, data errors: %0d, assertion failures: %0d",
			checks, errors, assert_fails);
		if (errors == 0 && assert_fails == 0 && checks == sent_count - lost_count) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

	initial begin : watchdog
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Run timed out after %0d cycles with %0d items still pending",
			TIMEOUT_CYCLES, pending);
		$display("Results checked: %0d, data errors: %0d", checks, errors);
		$display("*** FAILED ***");
		$finish;
	end

endmodule
